//--- design/lane_defines.svh
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

////////////////////
// Port counts
////////////////////
`define LANE_R_PORTS 4
`define LANE_W_PORTS 2

// Storage per lane
`define VRF_DEPTH    64
`define VMRF_DEPTH   32

// Data and control widths
`define WORD_W       32
`define ALU_CTRL_W   6

////////////////////
// Pipeline delays
////////////////////
// Read issue to operand out
`define READ_DELAY   2
// Stages before a write commits
`define WRITE_DELAY  2

`endif

//--- design/vrf_pkg.sv
`include "lane_defines.svh"

package vrf_pkg;

   // One element word of the VRF
   typedef logic [`WORD_W-1:0] word_t;

   // Addresses
   typedef logic [$clog2(`VRF_DEPTH)-1:0]  vrf_addr_t;
   typedef logic [$clog2(`VMRF_DEPTH)-1:0] vmrf_addr_t;

   // One enable per byte of a word
   typedef logic [`WORD_W/8-1:0] bwen_t;

   // Element width
   typedef enum logic [1:0] {
      SEW_BYTE = 2'd0,
      SEW_HALF = 2'd1,
      SEW_WORD = 2'd2
   } sew_t;

   // Byte position inside a word
   typedef logic [1:0] byte_sel_t;

endpackage

//--- design/op_pkg.sv
`include "lane_defines.svh"

package op_pkg;

   typedef logic [`ALU_CTRL_W-1:0] alu_ctrl_t;

   // Index of a VRF read port
   typedef logic [$clog2(`LANE_R_PORTS)-1:0] port_sel_t;

   // Write data source, code 3 writes zero
   typedef enum logic [1:0] {
      WSRC_ALU   = 2'd0,
      WSRC_LOAD  = 2'd1,
      WSRC_SLIDE = 2'd2
   } wsrc_t;

   // Sideband of one slot, travels alongside the read data
   typedef struct packed {
      alu_ctrl_t opcode;
      port_sel_t op3_sel;
      logic      rd_vld;
   } op_side_t;

   typedef struct packed {
      port_sel_t sel;
      logic      vld;
   } store_side_t;

   // One write request through the write pipeline
   typedef struct packed {
      vrf_pkg::vrf_addr_t  addr;
      vrf_pkg::word_t      data;
      vrf_pkg::bwen_t      bwen;
      logic                mask_en;
      logic                vmrf_wen;
      logic                mask_bit;
      vrf_pkg::vmrf_addr_t vmrf_addr;
   } wr_req_t;

endpackage

//--- design/stage_delay.sv
`timescale 1ns/1ns

module stage_delay #(
   parameter int  DEPTH     = 2,
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  payload_t d_i,
   output payload_t q_o
);

   payload_t pipe_q [DEPTH];

   // Shift line, stage 0 takes the input
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            pipe_q[i] <= '0;
         end
      end else begin
         pipe_q[0] <= d_i;
         for (int i = 1; i < DEPTH; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign q_o = pipe_q[DEPTH-1];

endmodule

//--- design/lane_regfile.sv
`timescale 1ns/1ns

module lane_regfile #(
   parameter int DEPTH   = 64,
   parameter int WIDTH   = $bits(vrf_pkg::word_t),
   parameter int LANES   = 4,
   parameter int R_PORTS = 4,
   parameter int W_PORTS = 2
) (
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic [R_PORTS-1:0][$clog2(DEPTH)-1:0]    raddr_i,
   output logic [R_PORTS-1:0][WIDTH-1:0]            rdata_o,
   input  logic [W_PORTS-1:0][$clog2(DEPTH)-1:0]    waddr_i,
   input  logic [W_PORTS-1:0][WIDTH-1:0]            wdata_i,
   input  logic [W_PORTS-1:0][LANES-1:0]            wen_i
);

   // Bits covered by one enable
   localparam int LW = WIDTH / LANES;

   logic [WIDTH-1:0] mem [DEPTH];

   ////////////////////
   // Write side
   ////////////////////
   // Later ports overwrite earlier ones on the same address
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < W_PORTS; w++) begin
         for (int l = 0; l < LANES; l++) begin
            if (wen_i[w][l]) begin
               mem[waddr_i[w]][l*LW +: LW] <= wdata_i[w][l*LW +: LW];
            end
         end
      end
   end

   ////////////////////
   // Read side
   ////////////////////
   // Registered read, a write in the same cycle is not yet visible
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_o <= '0;
      end else begin
         for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] <= mem[raddr_i[r]];
         end
      end
   end

endmodule

//--- design/read_data_prep.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module read_data_prep (
   input  logic                                        clk_i,
   input  logic                                        rst_i,
   input  vrf_pkg::word_t    [`LANE_R_PORTS-1:0]       rdata_i,
   input  vrf_pkg::byte_sel_t [`LANE_R_PORTS-1:0]      byte_sel_i,
   input  vrf_pkg::sew_t     [`LANE_W_PORTS-1:0]       sew_i,
   output vrf_pkg::word_t    [`LANE_R_PORTS-1:0]       prep_o
);

   import vrf_pkg::*;

   byte_sel_t [`LANE_R_PORTS-1:0] byte_sel_q;
   sew_t      [`LANE_W_PORTS-1:0] sew_q;
   word_t     [`LANE_R_PORTS-1:0] narrow;

   // Align the selects with the registered VRF data
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         byte_sel_q <= '0;
         for (int j = 0; j < `LANE_W_PORTS; j++) begin
            sew_q[j] <= SEW_WORD;
         end
      end else begin
         byte_sel_q <= byte_sel_i;
         sew_q      <= sew_i;
      end
   end

   // Slot j owns ports 2j and 2j+1
   always_comb begin
      for (int p = 0; p < `LANE_R_PORTS; p++) begin
         narrow[p] = '0;
         case (sew_q[p/2])
            SEW_BYTE: narrow[p][7:0]  = rdata_i[p][byte_sel_q[p]*8 +: 8];
            // Halfword picked by the low select bit
            SEW_HALF: narrow[p][15:0] = rdata_i[p][byte_sel_q[p][0]*16 +: 16];
            default:  narrow[p]       = rdata_i[p];
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      prep_o <= narrow;
   end

endmodule

//--- design/operand_router.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module operand_router (
   input  vrf_pkg::word_t   [`LANE_R_PORTS-1:0] prep_i,
   input  op_pkg::port_sel_t [`LANE_W_PORTS-1:0] op3_sel_i,
   input  op_pkg::port_sel_t                    store_sel_i,
   output vrf_pkg::word_t   [`LANE_W_PORTS-1:0] vs1_o,
   output vrf_pkg::word_t   [`LANE_W_PORTS-1:0] vs2_o,
   output vrf_pkg::word_t   [`LANE_W_PORTS-1:0] vs3_o,
   output vrf_pkg::word_t                       store_data_o
);

   ////////////////////
   // ALU operands
   ////////////////////
   // Fixed port pair per slot, op3 from any port
   always_comb begin
      for (int j = 0; j < `LANE_W_PORTS; j++) begin
         vs1_o[j] = prep_i[2*j];
         vs2_o[j] = prep_i[2*j+1];
         vs3_o[j] = prep_i[op3_sel_i[j]];
      end
   end

   // Store data taken from any read port
   assign store_data_o = prep_i[store_sel_i];

endmodule

//--- design/write_pipeline.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module write_pipeline (
   input  logic                                       clk_i,
   input  logic                                       rst_i,
   input  logic                [`LANE_W_PORTS-1:0]    alu_vld_i,
   input  vrf_pkg::vrf_addr_t  [`LANE_W_PORTS-1:0]    vrf_waddr_i,
   input  vrf_pkg::bwen_t      [`LANE_W_PORTS-1:0]    vrf_bwen_i,
   input  op_pkg::wsrc_t       [`LANE_W_PORTS-1:0]    vrf_write_src_i,
   input  vrf_pkg::word_t      [`LANE_W_PORTS-1:0]    alu_res_i,
   input  vrf_pkg::word_t                             load_data_i,
   input  vrf_pkg::word_t                             slide_data_i,
   input  logic                [`LANE_W_PORTS-1:0]    vector_mask_i,
   input  vrf_pkg::vmrf_addr_t [`LANE_W_PORTS-1:0]    vmrf_addr_i,
   input  logic                [`LANE_W_PORTS-1:0]    vmrf_wen_i,
   input  logic                [`LANE_W_PORTS-1:0]    alu_mask_bit_i,
   output vrf_pkg::vrf_addr_t  [`LANE_W_PORTS-1:0]    vrf_waddr_o,
   output vrf_pkg::word_t      [`LANE_W_PORTS-1:0]    vrf_wdata_o,
   output vrf_pkg::bwen_t      [`LANE_W_PORTS-1:0]    vrf_wen_o
);

   import vrf_pkg::*;
   import op_pkg::*;

   typedef wr_req_t [`LANE_W_PORTS-1:0] wr_req_arr_t;

   wr_req_arr_t req_d, req_s1, req_s2;
   logic       [`LANE_W_PORTS-1:0] vld_s2;
   vmrf_addr_t [`LANE_W_PORTS-1:0] vmrf_raddr, vmrf_waddr;
   logic       [`LANE_W_PORTS-1:0] mask_rd, vmrf_wdata, vmrf_wen;

   ////////////////////
   // Request build
   ////////////////////
   always_comb begin
      for (int j = 0; j < `LANE_W_PORTS; j++) begin
         case (vrf_write_src_i[j])
            WSRC_ALU:   req_d[j].data = alu_res_i[j];
            WSRC_LOAD:  req_d[j].data = load_data_i;
            WSRC_SLIDE: req_d[j].data = slide_data_i;
            default:    req_d[j].data = '0;
         endcase
         req_d[j].addr      = vrf_waddr_i[j];
         req_d[j].bwen      = vrf_bwen_i[j];
         req_d[j].mask_en   = vector_mask_i[j];
         req_d[j].vmrf_wen  = vmrf_wen_i[j];
         req_d[j].mask_bit  = alu_mask_bit_i[j];
         req_d[j].vmrf_addr = vmrf_addr_i[j];
      end
   end

   // Stage one is tapped to address the VMRF
   stage_delay #(.DEPTH(1), .payload_t(wr_req_arr_t)) i_req_s1 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (req_d),
      .q_o   (req_s1)
   );

   stage_delay #(.DEPTH(`WRITE_DELAY-1), .payload_t(wr_req_arr_t)) i_req_s2 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (req_s1),
      .q_o   (req_s2)
   );

   stage_delay #(.DEPTH(`WRITE_DELAY), .payload_t(logic [`LANE_W_PORTS-1:0])) i_vld (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (alu_vld_i),
      .q_o   (vld_s2)
   );

   ////////////////////
   // Mask register file
   ////////////////////
   always_comb begin
      for (int j = 0; j < `LANE_W_PORTS; j++) begin
         vmrf_raddr[j] = req_s1[j].vmrf_addr;
         vmrf_waddr[j] = req_s2[j].vmrf_addr;
         vmrf_wdata[j] = req_s2[j].mask_bit;
         vmrf_wen[j]   = req_s2[j].vmrf_wen & vld_s2[j];
      end
   end

   // Mask bit of stage one shows up with stage two
   lane_regfile #(
      .DEPTH   (`VMRF_DEPTH),
      .WIDTH   (1),
      .LANES   (1),
      .R_PORTS (`LANE_W_PORTS),
      .W_PORTS (`LANE_W_PORTS)
   ) i_vmrf (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .raddr_i (vmrf_raddr),
      .rdata_o (mask_rd),
      .waddr_i (vmrf_waddr),
      .wdata_i (vmrf_wdata),
      .wen_i   (vmrf_wen)
   );

   // Commit, masked lanes keep their old bytes
   always_comb begin
      for (int j = 0; j < `LANE_W_PORTS; j++) begin
         vrf_waddr_o[j] = req_s2[j].addr;
         vrf_wdata_o[j] = req_s2[j].data;
         vrf_wen_o[j]   = req_s2[j].bwen & {$bits(bwen_t){vld_s2[j]}};
         if (req_s2[j].mask_en) begin
            vrf_wen_o[j] = vrf_wen_o[j] & {$bits(bwen_t){mask_rd[j]}};
         end
      end
   end

endmodule

//--- design/vector_lane.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module vector_lane (
   input  logic                                      clk_i,
   input  logic                                      rst_i,
   // Read request
   input  vrf_pkg::vrf_addr_t  [`LANE_R_PORTS-1:0]   vrf_raddr_i,
   input  vrf_pkg::byte_sel_t  [`LANE_R_PORTS-1:0]   vrf_read_byte_sel_i,
   input  vrf_pkg::sew_t       [`LANE_W_PORTS-1:0]   vrf_read_sew_i,
   input  logic                [`LANE_W_PORTS-1:0]   read_data_valid_i,
   input  op_pkg::alu_ctrl_t   [`LANE_W_PORTS-1:0]   alu_ctrl_i,
   input  op_pkg::port_sel_t   [`LANE_W_PORTS-1:0]   op3_sel_i,
   input  op_pkg::port_sel_t                         store_data_sel_i,
   input  logic                                      store_data_valid_i,
   // Operands to the ALU
   output vrf_pkg::word_t      [`LANE_W_PORTS-1:0]   vs1_data_o,
   output vrf_pkg::word_t      [`LANE_W_PORTS-1:0]   vs2_data_o,
   output vrf_pkg::word_t      [`LANE_W_PORTS-1:0]   vs3_data_o,
   output op_pkg::alu_ctrl_t   [`LANE_W_PORTS-1:0]   alu_opmode_o,
   output logic                [`LANE_W_PORTS-1:0]   alu_vld_o,
   output vrf_pkg::word_t                            store_data_o,
   output logic                                      store_data_valid_o,
   // Write request
   input  logic                [`LANE_W_PORTS-1:0]   alu_vld_i,
   input  vrf_pkg::vrf_addr_t  [`LANE_W_PORTS-1:0]   vrf_waddr_i,
   input  vrf_pkg::bwen_t      [`LANE_W_PORTS-1:0]   vrf_bwen_i,
   input  op_pkg::wsrc_t       [`LANE_W_PORTS-1:0]   vrf_write_src_i,
   input  vrf_pkg::word_t      [`LANE_W_PORTS-1:0]   alu_res_i,
   input  vrf_pkg::word_t                            load_data_i,
   input  vrf_pkg::word_t                            slide_data_i,
   input  logic                [`LANE_W_PORTS-1:0]   vector_mask_i,
   input  vrf_pkg::vmrf_addr_t [`LANE_W_PORTS-1:0]   vmrf_addr_i,
   input  logic                [`LANE_W_PORTS-1:0]   vmrf_wen_i,
   input  logic                [`LANE_W_PORTS-1:0]   alu_mask_bit_i
);

   import vrf_pkg::*;
   import op_pkg::*;

   typedef op_side_t [`LANE_W_PORTS-1:0] op_side_arr_t;

   word_t       [`LANE_R_PORTS-1:0] vrf_rdata, prep;
   vrf_addr_t   [`LANE_W_PORTS-1:0] vrf_waddr;
   word_t       [`LANE_W_PORTS-1:0] vrf_wdata;
   bwen_t       [`LANE_W_PORTS-1:0] vrf_wen;
   op_side_arr_t                    side_d, side_q;
   port_sel_t   [`LANE_W_PORTS-1:0] op3_sel_q;
   store_side_t                     store_d, store_q;

   ////////////////////
   // Sidebands
   ////////////////////
   for (genvar j = 0; j < `LANE_W_PORTS; j++) begin : g_side
      assign side_d[j] = '{opcode: alu_ctrl_i[j], op3_sel: op3_sel_i[j],
                           rd_vld: read_data_valid_i[j]};
      assign alu_opmode_o[j] = side_q[j].opcode;
      assign alu_vld_o[j]    = side_q[j].rd_vld;
      assign op3_sel_q[j]    = side_q[j].op3_sel;
   end

   assign store_d            = '{sel: store_data_sel_i, vld: store_data_valid_i};
   assign store_data_valid_o = store_q.vld;

   stage_delay #(.DEPTH(`READ_DELAY), .payload_t(op_side_arr_t)) i_side_dly (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (side_d),
      .q_o   (side_q)
   );

   stage_delay #(.DEPTH(`READ_DELAY), .payload_t(store_side_t)) i_store_dly (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (store_d),
      .q_o   (store_q)
   );

   ////////////////////
   // Register file and read path
   ////////////////////
   lane_regfile #(
      .DEPTH   (`VRF_DEPTH),
      .WIDTH   (`WORD_W),
      .LANES   (`WORD_W/8),
      .R_PORTS (`LANE_R_PORTS),
      .W_PORTS (`LANE_W_PORTS)
   ) i_vrf (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .raddr_i (vrf_raddr_i),
      .rdata_o (vrf_rdata),
      .waddr_i (vrf_waddr),
      .wdata_i (vrf_wdata),
      .wen_i   (vrf_wen)
   );

   read_data_prep i_read_data_prep (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rdata_i    (vrf_rdata),
      .byte_sel_i (vrf_read_byte_sel_i),
      .sew_i      (vrf_read_sew_i),
      .prep_o     (prep)
   );

   operand_router i_operand_router (
      .prep_i       (prep),
      .op3_sel_i    (op3_sel_q),
      .store_sel_i  (store_q.sel),
      .vs1_o        (vs1_data_o),
      .vs2_o        (vs2_data_o),
      .vs3_o        (vs3_data_o),
      .store_data_o (store_data_o)
   );

   // Write side, commits two cycles after the strobe
   write_pipeline i_write_pipeline (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .alu_vld_i       (alu_vld_i),
      .vrf_waddr_i     (vrf_waddr_i),
      .vrf_bwen_i      (vrf_bwen_i),
      .vrf_write_src_i (vrf_write_src_i),
      .alu_res_i       (alu_res_i),
      .load_data_i     (load_data_i),
      .slide_data_i    (slide_data_i),
      .vector_mask_i   (vector_mask_i),
      .vmrf_addr_i     (vmrf_addr_i),
      .vmrf_wen_i      (vmrf_wen_i),
      .alu_mask_bit_i  (alu_mask_bit_i),
      .vrf_waddr_o     (vrf_waddr),
      .vrf_wdata_o     (vrf_wdata),
      .vrf_wen_o       (vrf_wen)
   );

endmodule

//--- verification/vector_lane_asserts.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module vector_lane_asserts (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic [`LANE_W_PORTS-1:0] read_data_valid_i,
   input logic                     store_data_valid_i,
   input logic [`LANE_W_PORTS-1:0] alu_vld_o,
   input logic                     store_data_valid_o
);

   // Sidebands trail the request by the read delay once out of reset
   property p_alu_vld_delay;
      @(posedge clk_i) ($past(rst_i, 1) && $past(rst_i, 2))
         |-> alu_vld_o == $past(read_data_valid_i, 2);
   endproperty

   property p_store_vld_delay;
      @(posedge clk_i) ($past(rst_i, 1) && $past(rst_i, 2))
         |-> store_data_valid_o == $past(store_data_valid_i, 2);
   endproperty

   // One reset edge is enough to clear both valids
   property p_reset_clears;
      @(posedge clk_i) !$past(rst_i)
         |-> (alu_vld_o == '0 && store_data_valid_o == 1'b0);
   endproperty

   a_alu_vld_delay: assert property (p_alu_vld_delay)
      else $error("alu_vld_o does not follow read_data_valid_i two cycles back");

   a_store_vld_delay: assert property (p_store_vld_delay)
      else $error("store_data_valid_o does not follow store_data_valid_i two cycles back");

   a_reset_clears: assert property (p_reset_clears)
      else $error("valid outputs not cleared after reset");

endmodule

//--- verification/vector_lane_tb.sv
`timescale 1ns/1ns
`include "lane_defines.svh"

module vector_lane_tb;

   import vrf_pkg::*;
   import op_pkg::*;

   localparam int CLK_HALF  = 20;
   localparam int DRIVE_DLY = 5;
   localparam int WAIT_MAX  = 8;

   // One stimulus row where write rows use addr[0] only
   typedef struct {
      string            name;
      bit               is_wr;
      int               slot;
      vrf_addr_t [3:0]  addr;
      logic [1:0]       src;
      sew_t             sew;
      byte_sel_t        bsel;
      bwen_t            bwen;
      bit               mask_en;
      bit               vmrf_wen;
      bit               mask_bit;
      vmrf_addr_t       vaddr;
      port_sel_t        op3;
      port_sel_t        st_sel;
      bit               st_vld;
      alu_ctrl_t        opcode;
   } row_t;

   logic                           clk_i;
   logic                           rst_i;
   vrf_addr_t  [`LANE_R_PORTS-1:0] vrf_raddr_i;
   byte_sel_t  [`LANE_R_PORTS-1:0] vrf_read_byte_sel_i;
   sew_t       [`LANE_W_PORTS-1:0] vrf_read_sew_i;
   logic       [`LANE_W_PORTS-1:0] read_data_valid_i;
   alu_ctrl_t  [`LANE_W_PORTS-1:0] alu_ctrl_i;
   port_sel_t  [`LANE_W_PORTS-1:0] op3_sel_i;
   port_sel_t                      store_data_sel_i;
   logic                           store_data_valid_i;
   word_t      [`LANE_W_PORTS-1:0] vs1_data_o;
   word_t      [`LANE_W_PORTS-1:0] vs2_data_o;
   word_t      [`LANE_W_PORTS-1:0] vs3_data_o;
   alu_ctrl_t  [`LANE_W_PORTS-1:0] alu_opmode_o;
   logic       [`LANE_W_PORTS-1:0] alu_vld_o;
   word_t                          store_data_o;
   logic                           store_data_valid_o;
   logic       [`LANE_W_PORTS-1:0] alu_vld_i;
   vrf_addr_t  [`LANE_W_PORTS-1:0] vrf_waddr_i;
   bwen_t      [`LANE_W_PORTS-1:0] vrf_bwen_i;
   wsrc_t      [`LANE_W_PORTS-1:0] vrf_write_src_i;
   word_t      [`LANE_W_PORTS-1:0] alu_res_i;
   word_t                          load_data_i;
   word_t                          slide_data_i;
   logic       [`LANE_W_PORTS-1:0] vector_mask_i;
   vmrf_addr_t [`LANE_W_PORTS-1:0] vmrf_addr_i;
   logic       [`LANE_W_PORTS-1:0] vmrf_wen_i;
   logic       [`LANE_W_PORTS-1:0] alu_mask_bit_i;

   row_t        table_q [$];
   word_t       vrf_model [`VRF_DEPTH];
   logic        vmrf_model [`VMRF_DEPTH];
   logic [31:0] rng_state;
   int          errors;
   int          checks;
   int          row_errs;

   vector_lane i_vector_lane (.*);

   bind vector_lane vector_lane_asserts i_lane_asserts (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .read_data_valid_i  (read_data_valid_i),
      .store_data_valid_i (store_data_valid_i),
      .alu_vld_o          (alu_vld_o),
      .store_data_valid_o (store_data_valid_o)
   );

   always #CLK_HALF clk_i = ~clk_i;

   ////////////////////
   // Helpers
   ////////////////////
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Zero-extended element as the ALU should see it
   function automatic word_t expect_elem(input word_t w, input sew_t sew, input byte_sel_t bs);
      case (sew)
         SEW_BYTE: return (w >> (8 * bs)) & 32'h0000_00ff;
         SEW_HALF: return (w >> (16 * bs[0])) & 32'h0000_ffff;
         default:  return w;
      endcase
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #DRIVE_DLY;
   endtask

   task automatic clear_inputs();
      vrf_raddr_i         = '0;
      vrf_read_byte_sel_i = '0;
      read_data_valid_i   = '0;
      alu_ctrl_i          = '0;
      op3_sel_i           = '0;
      store_data_sel_i    = '0;
      store_data_valid_i  = 1'b0;
      alu_vld_i           = '0;
      vrf_waddr_i         = '0;
      vrf_bwen_i          = '0;
      alu_res_i           = '0;
      load_data_i         = '0;
      slide_data_i        = '0;
      vector_mask_i       = '0;
      vmrf_addr_i         = '0;
      vmrf_wen_i          = '0;
      alu_mask_bit_i      = '0;
      for (int j = 0; j < `LANE_W_PORTS; j++) begin
         vrf_read_sew_i[j]  = SEW_WORD;
         vrf_write_src_i[j] = WSRC_ALU;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
         row_errs++;
      end
   endtask

   task automatic add_write(input string name, input int slot, input vrf_addr_t addr,
                            input logic [1:0] src, input bwen_t bwen, input bit mask_en,
                            input bit vmrf_wen, input bit mask_bit, input vmrf_addr_t vaddr);
      row_t r;
      r.name     = name;
      r.is_wr    = 1'b1;
      r.slot     = slot;
      r.addr[0]  = addr;
      r.src      = src;
      r.bwen     = bwen;
      r.mask_en  = mask_en;
      r.vmrf_wen = vmrf_wen;
      r.mask_bit = mask_bit;
      r.vaddr    = vaddr;
      table_q.push_back(r);
   endtask

   // Addresses are given as ports 3 down to 0
   task automatic add_read(input string name, input int slot, input vrf_addr_t [3:0] addr,
                           input sew_t sew, input byte_sel_t bsel, input port_sel_t op3,
                           input port_sel_t st_sel, input bit st_vld, input alu_ctrl_t opcode);
      row_t r;
      r.name   = name;
      r.is_wr  = 1'b0;
      r.slot   = slot;
      r.addr   = addr;
      r.sew    = sew;
      r.bsel   = bsel;
      r.op3    = op3;
      r.st_sel = st_sel;
      r.st_vld = st_vld;
      r.opcode = opcode;
      table_q.push_back(r);
   endtask

   ////////////////////
   // Row execution
   ////////////////////
   task automatic apply_write(input int idx);
      row_t  r;
      int    s;
      int    n;
      word_t data;
      bwen_t en;
      r = table_q[idx];
      s = r.slot;
      rng_state = xorshift(rng_state);
      alu_res_i[s] = rng_state;
      rng_state = xorshift(rng_state);
      load_data_i = rng_state;
      rng_state = xorshift(rng_state);
      slide_data_i = rng_state;
      alu_vld_i[s]       = 1'b1;
      vrf_waddr_i[s]     = r.addr[0];
      vrf_bwen_i[s]      = r.bwen;
      vrf_write_src_i[s] = wsrc_t'(r.src);
      vector_mask_i[s]   = r.mask_en;
      vmrf_addr_i[s]     = r.vaddr;
      vmrf_wen_i[s]      = r.vmrf_wen;
      alu_mask_bit_i[s]  = r.mask_bit;
      // Model update uses the mask bit from before this row's own VMRF write
      case (r.src)
         2'd0:    data = alu_res_i[s];
         2'd1:    data = load_data_i;
         2'd2:    data = slide_data_i;
         default: data = '0;
      endcase
      en = r.bwen;
      if (r.mask_en && vmrf_model[r.vaddr] !== 1'b1) begin
         en = '0;
      end
      for (int b = 0; b < 4; b++) begin
         if (en[b]) begin
            vrf_model[r.addr[0]][8*b +: 8] = data[8*b +: 8];
         end
      end
      if (r.vmrf_wen) begin
         vmrf_model[r.vaddr] = r.mask_bit;
      end
      // Commit happens on the third edge
      n = 0;
      while (n < `WRITE_DELAY + 1) begin
         next_cycle();
         n++;
         if (n == 1) begin
            clear_inputs();
         end
      end
   endtask

   task automatic apply_read(input int idx);
      row_t      r;
      int        s;
      int        n;
      word_t     exp_prep [`LANE_R_PORTS];
      sew_t      psew;
      byte_sel_t pbs;
      r = table_q[idx];
      s = r.slot;
      for (int p = 0; p < `LANE_R_PORTS; p++) begin
         vrf_raddr_i[p] = r.addr[p];
         // Ports of the other slot read whole words
         if (p / 2 == s) begin
            psew = r.sew;
            pbs  = r.bsel + byte_sel_t'(p % 2);
         end else begin
            psew = SEW_WORD;
            pbs  = '0;
         end
         vrf_read_byte_sel_i[p] = pbs;
         exp_prep[p] = expect_elem(vrf_model[r.addr[p]], psew, pbs);
      end
      vrf_read_sew_i[s]    = r.sew;
      read_data_valid_i[s] = 1'b1;
      alu_ctrl_i[s]        = r.opcode;
      op3_sel_i[s]         = r.op3;
      store_data_sel_i     = r.st_sel;
      store_data_valid_i   = r.st_vld;
      n = 0;
      do begin
         next_cycle();
         n++;
         if (n == 1) begin
            clear_inputs();
         end
      end while (alu_vld_o[s] !== 1'b1 && n < WAIT_MAX);
      if (alu_vld_o[s] !== 1'b1) begin
         $display("Timeout: alu_vld_o[%0d] stayed low for %0d cycles after the read",
                  s, WAIT_MAX);
         errors++;
         row_errs++;
      end else begin
         check_value("read latency", n, `READ_DELAY);
         check_value($sformatf("alu_opmode_o[%0d]", s), 32'(alu_opmode_o[s]), 32'(r.opcode));
         check_value($sformatf("alu_vld_o[%0d]", 1 - s), 32'(alu_vld_o[1-s]), 32'd0);
         check_value($sformatf("vs1_data_o[%0d]", s), vs1_data_o[s], exp_prep[2*s]);
         check_value($sformatf("vs2_data_o[%0d]", s), vs2_data_o[s], exp_prep[2*s+1]);
         check_value($sformatf("vs3_data_o[%0d]", s), vs3_data_o[s], exp_prep[r.op3]);
         check_value("store_data_o", store_data_o, exp_prep[r.st_sel]);
         check_value("store_data_valid_o", 32'(store_data_valid_o), 32'(r.st_vld));
      end
   endtask

   ////////////////////
   // Stimulus table
   ////////////////////
   task automatic build_table();
      add_write("alu word slot 0", 0, 6'd1, 2'd0, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_write("alu word slot 1", 1, 6'd2, 2'd0, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_write("load source", 0, 6'd3, 2'd1, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_write("slide source", 1, 6'd4, 2'd2, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_write("zero source", 0, 6'd5, 2'd3, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_write("mask target init", 1, 6'd6, 2'd0, 4'hf, 1'b0, 1'b0, 1'b0, 5'd0);
      add_read("word read slot 0", 0, {6'd4, 6'd3, 6'd2, 6'd1}, SEW_WORD, 2'd0,
               2'd2, 2'd3, 1'b1, 6'h15);
      add_read("word read slot 1", 1, {6'd2, 6'd1, 6'd4, 6'd3}, SEW_WORD, 2'd0,
               2'd0, 2'd1, 1'b0, 6'h2a);
      add_read("zero source read", 0, {6'd6, 6'd1, 6'd5, 6'd5}, SEW_WORD, 2'd0,
               2'd3, 2'd2, 1'b1, 6'h01);
      add_read("byte sel 0 and 1", 0, {6'd2, 6'd2, 6'd1, 6'd1}, SEW_BYTE, 2'd0,
               2'd1, 2'd0, 1'b1, 6'h07);
      add_read("byte sel 2 and 3", 1, {6'd3, 6'd3, 6'd4, 6'd4}, SEW_BYTE, 2'd2,
               2'd3, 2'd2, 1'b0, 6'h3f);
      add_read("half sel 0 and 1", 1, {6'd4, 6'd4, 6'd2, 6'd2}, SEW_HALF, 2'd0,
               2'd2, 2'd3, 1'b1, 6'h11);
      add_read("half sel 2 and 3", 0, {6'd2, 6'd1, 6'd3, 6'd3}, SEW_HALF, 2'd2,
               2'd0, 2'd1, 1'b1, 6'h22);
      // Mask sequence on word 6
      add_write("vmrf bit 7 clear", 1, 6'd6, 2'd0, 4'h0, 1'b0, 1'b1, 1'b0, 5'd7);
      add_write("masked write bit 0", 0, 6'd6, 2'd0, 4'hf, 1'b1, 1'b0, 1'b0, 5'd7);
      add_read("mask 0 keeps word", 0, {6'd1, 6'd2, 6'd6, 6'd6}, SEW_WORD, 2'd0,
               2'd3, 2'd0, 1'b1, 6'h10);
      add_write("vmrf bit 8 set", 0, 6'd6, 2'd0, 4'h0, 1'b0, 1'b1, 1'b1, 5'd8);
      add_write("masked write bit 1", 1, 6'd6, 2'd0, 4'b0101, 1'b1, 1'b0, 1'b0, 5'd8);
      add_read("mask 1 enabled bytes", 1, {6'd6, 6'd6, 6'd2, 6'd1}, SEW_WORD, 2'd0,
               2'd3, 2'd2, 1'b1, 6'h2c);
      add_write("mask off write", 0, 6'd6, 2'd1, 4'hf, 1'b0, 1'b0, 1'b0, 5'd7);
      add_read("mask off read", 0, {6'd3, 6'd6, 6'd6, 6'd6}, SEW_WORD, 2'd0,
               2'd1, 2'd3, 1'b1, 6'h05);
   endtask

   initial begin
      clk_i     = 1'b0;
      rst_i     = 1'b0;
      rng_state = 32'd79;
      errors    = 0;
      checks    = 0;
      clear_inputs();
      // Valid inputs stay high through reset so only the reset clears the pipes
      read_data_valid_i  = '1;
      store_data_valid_i = 1'b1;
      build_table();
      for (int c = 0; c < 3; c++) begin
         next_cycle();
      end
      rst_i = 1'b1;
      clear_inputs();

      row_errs = 0;
      check_value("alu_vld_o", 32'(alu_vld_o), 32'd0);
      check_value("store_data_valid_o", 32'(store_data_valid_o), 32'd0);
      $display("test 0 reset: %s", row_errs == 0 ? "ok" : "error");

      for (int i = 0; i < table_q.size(); i++) begin
         row_errs = 0;
         if (table_q[i].is_wr) begin
            apply_write(i);
         end else begin
            apply_read(i);
         end
         $display("test %0d %s: %s", i + 1, table_q[i].name, row_errs == 0 ? "ok" : "error");
      end

      $display("%0d tests, %0d checks, %0d errors", table_q.size() + 1, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- vector_lane.f
+incdir+design
design/vrf_pkg.sv
design/op_pkg.sv
design/stage_delay.sv
design/lane_regfile.sv
design/read_data_prep.sv
design/operand_router.sv
design/write_pipeline.sv
design/vector_lane.sv
verification/vector_lane_asserts.sv
verification/vector_lane_tb.sv

//--- Makefile
SIM := obj_dir/Vvector_lane_tb
SRC := vector_lane.f $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRC)
	verilator --binary --timing --assert -f vector_lane.f --top-module vector_lane_tb \
		-Mdir obj_dir -o Vvector_lane_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
